// ==== build.f ====
logic/uart_pkg.sv
logic/baud_tick_gen.sv
logic/uart_rx_lane.sv
logic/rx_apb_regs.sv
logic/uart_rx_hub.sv
verification/uart_rx_hub_tb.sv

// ==== Bender.yml ====
package:
  name: uart_rx_hub

sources:
  - logic/uart_pkg.sv
  - logic/baud_tick_gen.sv
  - logic/uart_rx_lane.sv
  - logic/rx_apb_regs.sv
  - logic/uart_rx_hub.sv
  - target: simulation
    files:
      - verification/uart_rx_hub_tb.sv

// ==== verification/uart_rx_hub_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_rx_hub_tb
	import uart_pkg::*;
();

	localparam int BIT_CLKS = 64;  // CLK_DIV 4 times 16 ticks
	localparam int M_FULL   = 8;   // model layout {ferr, ovr, full, byte}
	localparam int M_OVR    = 9;
	localparam int M_FERR   = 10;

	logic        clk = 1'b0;
	logic        rst_n;
	logic [3:0]  rx;
	logic [7:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        irq;
	logic [31:0] seed = 32'hcfeab280;
	logic [10:0] model [4];
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          test_base = 0;

	uart_rx_hub #(
		.NUM_LANES (4),
		.CLK_DIV   (4)
	) dut_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.rx      (rx),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.irq     (irq)
	);

	always #4 clk = ~clk;

	function automatic logic [7:0] next_byte();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[23:16];  // upper bits of the lcg are the better ones
	endfunction

	// replays frames on top of the previous lane state
	function automatic logic [10:0] exp_status(input logic [10:0] prev, input logic [8:0] hist[$]);
		logic [10:0] st;
		st = prev;
		foreach (hist[i]) begin
			if (hist[i][8]) begin
				if (st[M_FULL]) begin
					st[M_OVR] = 1'b1;
				end
				st[7:0]    = hist[i][7:0];
				st[M_FULL] = 1'b1;
			end else begin
				st[M_FERR] = 1'b1;  // bad stop bit, byte dropped
			end
		end
		return st;
	endfunction

	task automatic compare_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("ERROR %0t ns %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		int n;
		@(posedge clk);
		#1;
		paddr  = addr;
		pwrite = wr;
		pwdata = wdata;
		psel   = 1'b1;
		@(posedge clk);
		#1;
		penable = 1'b1;
		#2;
		n = 0;
		while (pready !== 1'b1 && n < 20) begin
			@(posedge clk);
			#3;
			n++;
		end
		if (pready !== 1'b1) begin
			errors++;
			$display("pready never went high for the access to address %h", addr);
		end
		rdata = prdata;  // combinational in the access phase
		err   = pslverr;
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic send_frame(input int lane, input logic [7:0] data, input logic stop);
		logic [9:0] bits;
		bits = {stop, data, 1'b0};
		@(posedge clk);
		#1;
		for (int i = 0; i < 10; i++) begin
			rx[lane] = bits[i];
			repeat (BIT_CLKS) @(posedge clk);
			#1;
		end
		rx[lane] = 1'b1;
	endtask

	task automatic settle();
		repeat (200) @(posedge clk);
		#1;
	endtask

	task automatic check_status(input int lane);
		logic [31:0] rd;
		logic [31:0] exp;
		logic        err;
		exp = '0;
		exp[STAT_FULL]    = model[lane][M_FULL];
		exp[STAT_OVERRUN] = model[lane][M_OVR];
		exp[STAT_FERR]    = model[lane][M_FERR];
		apb_access(8'(lane * LANE_STRIDE + REG_STATUS), 1'b0, 32'h0, rd, err);
		compare_reg($sformatf("lane%0d status", lane), exp, rd);
		compare_reg($sformatf("lane%0d pslverr", lane), 32'h0, {31'h0, err});
	endtask

	task automatic check_data(input int lane);
		logic [31:0] rd;
		logic        err;
		apb_access(8'(lane * LANE_STRIDE + REG_DATA), 1'b0, 32'h0, rd, err);
		compare_reg($sformatf("lane%0d data", lane), {24'h0, model[lane][7:0]}, rd);
		compare_reg($sformatf("lane%0d pslverr", lane), 32'h0, {31'h0, err});
		model[lane][M_FULL] = 1'b0;  // read clears full
	endtask

	task automatic clear_flags(input int lane, input logic [31:0] mask);
		logic [31:0] rd;
		logic        err;
		apb_access(8'(lane * LANE_STRIDE + REG_STATUS), 1'b1, mask, rd, err);
		compare_reg($sformatf("lane%0d pslverr", lane), 32'h0, {31'h0, err});
		if (mask[STAT_OVERRUN]) begin
			model[lane][M_OVR] = 1'b0;
		end
		if (mask[STAT_FERR]) begin
			model[lane][M_FERR] = 1'b0;
		end
	endtask

	task automatic check_irq();
		logic exp;
		exp = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		foreach (model[k]) begin
			exp = exp | model[k][M_FULL] | model[k][M_OVR] | model[k][M_FERR];
		end
		compare_reg("irq", {31'h0, exp}, {31'h0, irq});
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s: %s", tests, name, (errors == test_base) ? "ok" : "FAILED");
		test_base = errors;
	endtask

	initial begin
		logic [7:0]  b [4];
		logic [8:0]  hist[$];
		logic [31:0] rd;
		logic        err;
		logic        dup;
		rst_n   = 1'b0;
		rx      = '1;  // idle lines
		paddr   = '0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = '0;
		foreach (model[k]) begin
			model[k] = '0;
		end
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		for (int k = 0; k < 4; k++) begin
			check_status(k);
			check_data(k);
		end
		check_irq();
		end_test("reset state");

		for (int k = 0; k < 4; k++) begin
			b[k] = next_byte();
			send_frame(k, b[k], 1'b1);
			hist = {};
			hist.push_back({1'b1, b[k]});
			model[k] = exp_status(model[k], hist);
		end
		settle();
		check_irq();
		for (int k = 0; k < 4; k++) begin
			check_status(k);
			check_data(k);
			check_status(k);
			check_irq();  // low only after the last lane
		end
		end_test("single byte per lane");

		for (int k = 0; k < 4; k++) begin
			dup = 1'b1;
			while (dup) begin
				b[k] = next_byte();
				dup = 1'b0;
				for (int j = 0; j < k; j++) begin
					if (b[j] == b[k]) begin
						dup = 1'b1;
					end
				end
			end
			hist = {};
			hist.push_back({1'b1, b[k]});
			model[k] = exp_status(model[k], hist);
		end
		fork
			send_frame(0, b[0], 1'b1);
			send_frame(1, b[1], 1'b1);
			send_frame(2, b[2], 1'b1);
			send_frame(3, b[3], 1'b1);
		join
		settle();
		for (int k = 0; k < 4; k++) begin
			check_data(k);
		end
		check_irq();
		end_test("simultaneous lanes");

		b[0] = next_byte();
		b[1] = next_byte();
		send_frame(0, b[0], 1'b1);
		send_frame(0, b[1], 1'b1);  // no read in between
		hist = {};
		hist.push_back({1'b1, b[0]});
		hist.push_back({1'b1, b[1]});
		model[0] = exp_status(model[0], hist);
		settle();
		check_status(0);
		check_irq();
		clear_flags(0, 32'(1) << STAT_OVERRUN);
		check_status(0);
		check_data(0);
		check_status(0);
		check_irq();
		end_test("overrun");

		b[2] = next_byte();
		send_frame(2, b[2], 1'b0);
		hist = {};
		hist.push_back({1'b0, b[2]});
		model[2] = exp_status(model[2], hist);
		settle();
		check_status(2);
		check_irq();
		clear_flags(2, 32'(1) << STAT_FERR);
		check_status(2);
		check_irq();
		end_test("frame error");

		b[0] = next_byte();
		send_frame(0, b[0], 1'b0);  // lane 0 flag that a stray write could clear
		hist = {};
		hist.push_back({1'b0, b[0]});
		model[0] = exp_status(model[0], hist);
		settle();
		apb_access(8'h40, 1'b0, 32'h0, rd, err);  // lane 4 does not exist
		compare_reg("pslverr lane 4 read", 32'h1, {31'h0, err});
		apb_access(8'h08, 1'b1, 32'h7, rd, err);
		compare_reg("pslverr offset 8 write", 32'h1, {31'h0, err});
		apb_access(8'h18, 1'b0, 32'h0, rd, err);
		compare_reg("pslverr offset 8 read", 32'h1, {31'h0, err});
		b[1] = next_byte();
		send_frame(1, b[1], 1'b1);
		hist = {};
		hist.push_back({1'b1, b[1]});
		model[1] = exp_status(model[1], hist);
		settle();
		check_status(1);
		check_data(1);
		check_status(0);
		end_test("address errors");

		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/uart_rx_hub.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_rx_hub
	import uart_pkg::*;
#(
	parameter int NUM_LANES = 4,
	parameter int CLK_DIV   = 4
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [NUM_LANES-1:0] rx,
	input  logic [7:0]           paddr,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  logic [31:0]          pwdata,
	output logic [31:0]          prdata,
	output logic                 pready,
	output logic                 pslverr,
	output logic                 irq
);

	wire                                tick;        // shared 16x strobe
	wire [NUM_LANES-1:0][DATA_BITS-1:0] lane_data;
	wire [NUM_LANES-1:0]                lane_valid;
	wire [NUM_LANES-1:0]                lane_ferr;

	baud_tick_gen #(
		.CLK_DIV (CLK_DIV)
	) tick_gen_i (
		.clk   (clk),
		.rst_n (rst_n),
		.tick  (tick)
	);

	for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
		uart_rx_lane lane_i (
			.clk        (clk),
			.rst_n      (rst_n),
			.tick       (tick),
			.rx         (rx[k]),
			.lane_data  (lane_data[k]),
			.lane_valid (lane_valid[k]),
			.lane_ferr  (lane_ferr[k])
		);
	end

	rx_apb_regs #(
		.NUM_LANES (NUM_LANES)
	) regs_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.lane_data  (lane_data),
		.lane_valid (lane_valid),
		.lane_ferr  (lane_ferr),
		.paddr      (paddr),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.irq        (irq)
	);

endmodule

`default_nettype wire

// ==== logic/rx_apb_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module rx_apb_regs
	import uart_pkg::*;
#(
	parameter int NUM_LANES = 4
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [NUM_LANES-1:0][DATA_BITS-1:0] lane_data,
	input  logic [NUM_LANES-1:0]                lane_valid,
	input  logic [NUM_LANES-1:0]                lane_ferr,
	input  logic [7:0]                          paddr,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  logic [31:0]                         pwdata,
	output logic [31:0]                         prdata,
	output logic                                pready,
	output logic                                pslverr,
	output logic                                irq
);

	logic [7:0]                          lane_sel;  // lane window index
	logic [7:0]                          reg_off;   // offset inside the window
	logic                                addr_ok;
	logic                                access;    // apb access phase
	logic                                rd_data;   // data read, clears full
	logic                                wr_stat;   // status write, w1c
	logic [NUM_LANES-1:0][DATA_BITS-1:0] hold_q;
	logic [NUM_LANES-1:0]                full_q;
	logic [NUM_LANES-1:0]                ovr_q;
	logic [NUM_LANES-1:0]                ferr_q;

	assign lane_sel = paddr / 8'(LANE_STRIDE);
	assign reg_off  = paddr % 8'(LANE_STRIDE);
	assign addr_ok  = (lane_sel < 8'(NUM_LANES))
		&& (reg_off == REG_DATA || reg_off == REG_STATUS);

	assign access  = psel & penable;
	assign rd_data = access & ~pwrite & addr_ok & (reg_off == REG_DATA);
	assign wr_stat = access & pwrite & addr_ok & (reg_off == REG_STATUS);

	assign pready  = 1'b1;               // no wait states
	assign pslverr = access & ~addr_ok;

	// a new byte or error beats any clear in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hold_q <= '0;
			full_q <= '0;
			ovr_q  <= '0;
			ferr_q <= '0;
		end else begin
			for (int k = 0; k < NUM_LANES; k++) begin
				if (lane_valid[k]) begin
					hold_q[k] <= lane_data[k];
					full_q[k] <= 1'b1;
				end else if (rd_data && lane_sel == 8'(k)) begin
					full_q[k] <= 1'b0;
				end

				if (lane_valid[k] && full_q[k]) begin
					ovr_q[k] <= 1'b1;  // unread byte lost
				end else if (wr_stat && lane_sel == 8'(k) && pwdata[STAT_OVERRUN]) begin
					ovr_q[k] <= 1'b0;
				end

				if (lane_ferr[k]) begin
					ferr_q[k] <= 1'b1;
				end else if (wr_stat && lane_sel == 8'(k) && pwdata[STAT_FERR]) begin
					ferr_q[k] <= 1'b0;
				end
			end
		end
	end

	// read data only during a valid read access
	always_comb begin
		prdata = '0;
		for (int k = 0; k < NUM_LANES; k++) begin
			if (access && !pwrite && addr_ok && lane_sel == 8'(k)) begin
				if (reg_off == REG_DATA) begin
					prdata[DATA_BITS-1:0] = hold_q[k];
				end else begin
					prdata[STAT_FULL]    = full_q[k];
					prdata[STAT_OVERRUN] = ovr_q[k];
					prdata[STAT_FERR]    = ferr_q[k];
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq <= 1'b0;
		end else begin
			irq <= |{full_q, ovr_q, ferr_q};  // any lane needs service
		end
	end

endmodule

`default_nettype wire

// ==== logic/uart_rx_lane.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_rx_lane
	import uart_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 tick,
	input  logic                 rx,
	output logic [DATA_BITS-1:0] lane_data,
	output logic                 lane_valid,
	output logic                 lane_ferr
);

	localparam int BIT_W = $clog2(DATA_BITS);

	logic [2:0]       rx_sync;   // three flop synchronizer
	logic             rx_s;      // synchronized line
	logic             fall_edge;
	lane_state_e      state;
	logic [3:0]       tick_cnt;  // oversample ticks, wraps every bit
	logic [BIT_W-1:0] bit_cnt;   // data bit index
	logic             mid;       // sample point of the current bit

	// line idles high, so reset to 1
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_sync <= 3'b111;
		end else begin
			rx_sync <= {rx_sync[1:0], rx};
		end
	end

	assign rx_s      = rx_sync[2];
	assign fall_edge = rx_sync[2] & ~rx_sync[1];  // high to low between last two stages
	assign mid       = tick && (tick_cnt == 4'(MID_TICK));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
		end else begin
			case (state)
				IDLE: begin
					tick_cnt <= '0;
					bit_cnt  <= '0;
					if (fall_edge) begin
						state <= START;
					end
				end
				START: begin
					if (tick) begin
						tick_cnt <= tick_cnt + 1'b1;
					end
					if (mid) begin
						state <= rx_s ? IDLE : DATA;  // glitch, not a start bit
					end
				end
				DATA: begin
					if (tick) begin
						tick_cnt <= tick_cnt + 1'b1;
					end
					if (mid) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == BIT_W'(DATA_BITS - 1)) begin
							state <= STOP;
						end
					end
				end
				STOP: begin
					if (tick) begin
						tick_cnt <= tick_cnt + 1'b1;
					end
					if (mid) begin
						state <= IDLE;  // rearm right at stop middle
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// lsb first, new bits enter at the top
	always_ff @(posedge clk) begin
		if (state == DATA && mid) begin
			lane_data <= {rx_s, lane_data[DATA_BITS-1:1]};
		end
	end

	// stop bit decides between a good byte and a framing error
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lane_valid <= 1'b0;
			lane_ferr  <= 1'b0;
		end else begin
			lane_valid <= (state == STOP) && mid && rx_s;
			lane_ferr  <= (state == STOP) && mid && !rx_s;
		end
	end

endmodule

`default_nettype wire

// ==== logic/baud_tick_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module baud_tick_gen #(
	parameter int CLK_DIV = 4
) (
	input  logic clk,
	input  logic rst_n,
	output logic tick
);

	localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

	logic [CNT_W-1:0] div_cnt;  // clocks since last tick
	logic             wrap;

	assign wrap = (div_cnt == CNT_W'(CLK_DIV - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else if (wrap) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// one clock wide strobe on the wrap
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick <= 1'b0;
		end else begin
			tick <= wrap;
		end
	end

endmodule

`default_nettype wire

// ==== logic/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

	// frame format
	localparam int DATA_BITS  = 8;
	localparam int OVERSAMPLE = 16;  // ticks per bit
	localparam int MID_TICK   = 7;   // sample point inside a bit

	// receive lane FSM
	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} lane_state_e;

	// offsets inside one lane window
	typedef enum logic [7:0] {
		REG_DATA   = 8'h00,
		REG_STATUS = 8'h04
	} reg_off_e;

	localparam int LANE_STRIDE = 16;  // bytes per lane window

	// status register bit positions
	localparam int STAT_FULL    = 0;
	localparam int STAT_OVERRUN = 1;
	localparam int STAT_FERR    = 2;

endpackage

`default_nettype wire
